//--- design/uart_pkg.sv
`default_nettype none

package uart_pkg;

	typedef enum logic [1:0] {
		PARITY_NONE = 2'd0,  // frame carries no parity bit
		PARITY_EVEN = 2'd1,  // ones count including parity is even
		PARITY_ODD  = 2'd2   // ones count including parity is odd
	} parity_mode_e;

	typedef enum logic [3:0] {
		RX_IDLE   = 4'd0,  // line idle, waiting for a start edge
		RX_START  = 4'd1,  // start bit, checked at its middle
		RX_DATA   = 4'd2,  // data bits, lsb first
		RX_PARITY = 4'd3,  // parity bit, only when parity is on
		RX_STOP   = 4'd4   // stop bit, frame result is produced here
	} rx_state_e;

	localparam int RX_SYNC_STAGES = 3;  // flops on the asynchronous serial input

	// widest data word the parity function accepts
	localparam int PARITY_WORD_W = 32;

	typedef logic [PARITY_WORD_W-1:0] parity_word_t;  // narrower words are zero extended

	// parity bit to send or expect for a data word
	function automatic logic calc_parity(
		input parity_word_t data,
		input parity_mode_e mode
	);
		logic ones_odd;
		ones_odd = ^data;  // zero padding does not change the xor
		case (mode)
			PARITY_EVEN: calc_parity = ones_odd;
			PARITY_ODD:  calc_parity = ~ones_odd;
			default:     calc_parity = 1'b0;  // unused when parity is off
		endcase
	endfunction

endpackage

`default_nettype wire

//--- design/rx_sample_if.sv
`timescale 1ns/10ps
`default_nettype none

// link between the receiver front end and the receiver bit fsm
interface rx_sample_if;

	logic line_synced;     // serial line after the synchronizer
	logic start_detected;  // falling edge seen while the receiver is idle
	logic sample_strobe;   // one cycle pulse in the middle of each bit
	logic frame_active;    // fsm is inside a frame

	modport front (
		output line_synced,
		output start_detected,
		output sample_strobe,
		input  frame_active
	);

	modport fsm (
		input  line_synced,
		input  start_detected,
		input  sample_strobe,
		output frame_active
	);

endinterface

`default_nettype wire

//--- design/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
	parameter int                     DATA_WIDTH     = 8,
	parameter int                     CLOCKS_PER_BIT = 8,
	parameter uart_pkg::parity_mode_e PARITY_MODE    = uart_pkg::PARITY_EVEN
) (
	input  logic                  tx_clk,
	input  logic                  reset_tx,
	input  logic                  i_enable,  // taken only while o_busy is low
	input  logic [DATA_WIDTH-1:0] i_data,
	output logic                  o_busy,
	output logic                  o_serial
);

	import uart_pkg::*;

	localparam int PARITY_BITS = (PARITY_MODE == PARITY_NONE) ? 0 : 1;
	localparam int FRAME_BITS  = 2 + DATA_WIDTH + PARITY_BITS;  // start + data + parity + stop
	localparam int BAUD_W      = $clog2(CLOCKS_PER_BIT);
	localparam int BIT_W       = $clog2(FRAME_BITS);

	localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(CLOCKS_PER_BIT - 1);  // last cycle of a bit
	localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(FRAME_BITS - 1);  // stop bit index

	logic [FRAME_BITS-1:0] frame_w;     // frame built from i_data, start bit at bit 0
	logic [FRAME_BITS-2:0] shift_q;     // bits still waiting behind the one on the line
	logic                  busy_q;
	logic                  serial_q;    // registered line driver
	logic [BAUD_W-1:0]     baud_cnt_q;  // cycles spent in the current bit
	logic [BIT_W-1:0]      bit_cnt_q;   // index of the bit on the line
	logic                  accept_w;
	logic                  bit_end_w;

	assign accept_w  = i_enable && !busy_q;  // load when idle
	assign bit_end_w = busy_q && (baud_cnt_q == BAUD_LAST);

	generate
		if (PARITY_BITS != 0) begin : g_parity
			assign frame_w = {1'b1, calc_parity(parity_word_t'(i_data), PARITY_MODE),
				i_data, 1'b0};  // stop, parity, data lsb first, start
		end else begin : g_no_parity
			assign frame_w = {1'b1, i_data, 1'b0};  // stop, data, start
		end
	endgenerate

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			busy_q     <= 1'b0;
			serial_q   <= 1'b1;  // idle line is high
			baud_cnt_q <= '0;
			bit_cnt_q  <= '0;
		end else if (accept_w) begin
			busy_q     <= 1'b1;
			serial_q   <= frame_w[0];  // start bit goes out on the next cycle
			baud_cnt_q <= '0;
			bit_cnt_q  <= '0;
		end else if (busy_q) begin
			if (bit_end_w) begin
				baud_cnt_q <= '0;
				if (bit_cnt_q == BIT_LAST) begin
					busy_q    <= 1'b0;  // stop bit done, ready for the next word
					serial_q  <= 1'b1;
					bit_cnt_q <= '0;
				end else begin
					serial_q  <= shift_q[0];  // next bit onto the line
					bit_cnt_q <= bit_cnt_q + 1'b1;
				end
			end else begin
				baud_cnt_q <= baud_cnt_q + 1'b1;
			end
		end
	end

	// piso register, word latched here on acceptance
	always_ff @(posedge tx_clk) begin
		if (accept_w) begin
			shift_q <= frame_w[FRAME_BITS-1:1];
		end else if (bit_end_w) begin
			shift_q <= {1'b1, shift_q[FRAME_BITS-2:1]};  // fill with idle level
		end
	end

	assign o_busy   = busy_q;
	assign o_serial = serial_q;

endmodule

`default_nettype wire

//--- design/uart_rx_front.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx_front #(
	parameter int CLOCKS_PER_BIT = 8
) (
	input logic        tx_clk,
	input logic        reset_tx,
	input logic        i_serial,  // asynchronous serial input
	rx_sample_if.front smp
);

	import uart_pkg::*;

	localparam int CNT_W = $clog2(CLOCKS_PER_BIT);

	localparam logic [CNT_W-1:0] HALF_LOAD = CNT_W'(CLOCKS_PER_BIT / 2 - 1);  // start to first middle
	localparam logic [CNT_W-1:0] FULL_LOAD = CNT_W'(CLOCKS_PER_BIT - 1);  // middle to next middle

	logic [RX_SYNC_STAGES-1:0] sync_q;        // synchronizer chain, oldest sample on top
	logic                      frame_prev_q;  // frame_active one cycle ago
	logic                      run_q;         // strobe counter running
	logic [CNT_W-1:0]          cnt_q;         // cycles left to the next strobe
	logic                      frame_fall_w;
	logic                      start_w;

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			sync_q <= '1;  // line assumed idle high
		end else begin
			sync_q <= {sync_q[RX_SYNC_STAGES-2:0], i_serial};
		end
	end

	// low arriving at the last stage, so line_synced falls next cycle
	assign start_w = sync_q[RX_SYNC_STAGES-1] && !sync_q[RX_SYNC_STAGES-2]
		&& !smp.frame_active && !run_q;

	assign frame_fall_w = frame_prev_q && !smp.frame_active;

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			frame_prev_q <= 1'b0;
		end else begin
			frame_prev_q <= smp.frame_active;
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx || frame_fall_w) begin
			run_q <= 1'b0;  // frame over or false start, wait for a new edge
			cnt_q <= '0;
		end else if (start_w) begin
			run_q <= 1'b1;
			cnt_q <= HALF_LOAD;  // first strobe CLOCKS_PER_BIT/2 cycles after start
		end else if (run_q) begin
			if (cnt_q == '0) begin
				cnt_q <= FULL_LOAD;
			end else begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
	end

	assign smp.line_synced    = sync_q[RX_SYNC_STAGES-1];
	assign smp.start_detected = start_w;
	assign smp.sample_strobe  = run_q && (cnt_q == '0);  // bit middle

endmodule

`default_nettype wire

//--- design/uart_rx_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx_fsm #(
	parameter int                     DATA_WIDTH  = 8,
	parameter uart_pkg::parity_mode_e PARITY_MODE = uart_pkg::PARITY_EVEN
) (
	input  logic                  tx_clk,
	input  logic                  reset_tx,
	rx_sample_if.fsm              smp,
	output logic [DATA_WIDTH-1:0] o_rx_data,     // last received word
	output logic                  o_data_valid,  // one cycle per received frame
	output logic                  o_rx_error     // parity or stop bit wrong
);

	import uart_pkg::*;

	localparam int CNT_W = $clog2(DATA_WIDTH);

	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DATA_WIDTH - 1);

	rx_state_e             state_q;
	logic [CNT_W-1:0]      bit_cnt_q;  // data bits taken so far
	logic [DATA_WIDTH-1:0] shift_q;    // data bits enter at the top, lsb ends at bit 0
	logic                  par_err_q;  // parity mismatch of the current frame
	logic [DATA_WIDTH-1:0] rx_data_q;
	logic                  valid_q;
	logic                  error_q;
	logic                  take_data_w;

	assign take_data_w = (state_q == RX_DATA) && smp.sample_strobe;

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state_q   <= RX_IDLE;
			bit_cnt_q <= '0;
			par_err_q <= 1'b0;
			rx_data_q <= '0;
			valid_q   <= 1'b0;
			error_q   <= 1'b0;
		end else begin
			valid_q <= 1'b0;  // single cycle pulse
			error_q <= 1'b0;  // error only rides on valid
			case (state_q)
				RX_IDLE: begin
					if (smp.start_detected) begin
						state_q <= RX_START;
					end
				end
				RX_START: begin
					if (smp.sample_strobe) begin
						if (smp.line_synced) begin
							state_q <= RX_IDLE;  // glitch, line back high at mid start
						end else begin
							state_q   <= RX_DATA;
							bit_cnt_q <= '0;
							par_err_q <= 1'b0;
						end
					end
				end
				RX_DATA: begin
					if (smp.sample_strobe) begin
						if (bit_cnt_q == LAST_BIT) begin
							state_q <= (PARITY_MODE == PARITY_NONE) ? RX_STOP : RX_PARITY;
						end else begin
							bit_cnt_q <= bit_cnt_q + 1'b1;
						end
					end
				end
				RX_PARITY: begin
					if (smp.sample_strobe) begin
						// all data bits are in the shift register by now
						par_err_q <= smp.line_synced
							^ calc_parity(parity_word_t'(shift_q), PARITY_MODE);
						state_q   <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (smp.sample_strobe) begin
						rx_data_q <= shift_q;
						valid_q   <= 1'b1;
						error_q   <= par_err_q || !smp.line_synced;  // stop bit must be high
						state_q   <= RX_IDLE;
					end
				end
				default: begin
					state_q <= RX_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge tx_clk) begin
		if (take_data_w) begin
			shift_q <= {smp.line_synced, shift_q[DATA_WIDTH-1:1]};  // lsb first
		end
	end

	assign smp.frame_active = (state_q != RX_IDLE);  // falls the cycle after the stop strobe

	assign o_rx_data    = rx_data_q;
	assign o_data_valid = valid_q;
	assign o_rx_error   = error_q;

endmodule

`default_nettype wire

//--- design/uart_top.sv
`timescale 1ns/10ps
`default_nettype none

module uart_top #(
	parameter int                     DATA_WIDTH     = 8,
	parameter int                     CLOCKS_PER_BIT = 8,  // even, at least 4
	parameter uart_pkg::parity_mode_e PARITY_MODE    = uart_pkg::PARITY_EVEN
) (
	input  logic                  tx_clk,
	input  logic                  reset_tx,
	// transmit side
	input  logic                  i_enable,
	input  logic [DATA_WIDTH-1:0] i_data,
	output logic                  o_busy,
	output logic                  o_serial,
	// receive side
	input  logic                  i_serial,
	output logic [DATA_WIDTH-1:0] o_rx_data,
	output logic                  o_data_valid,
	output logic                  o_rx_error
);

	rx_sample_if smp_if ();  // front end to fsm

	uart_tx #(
		.DATA_WIDTH     (DATA_WIDTH),
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT),
		.PARITY_MODE    (PARITY_MODE)
	) uart_tx_i (
		.tx_clk   (tx_clk),
		.reset_tx (reset_tx),
		.i_enable (i_enable),
		.i_data   (i_data),
		.o_busy   (o_busy),
		.o_serial (o_serial)
	);

	uart_rx_front #(
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT)
	) uart_rx_front_i (
		.tx_clk   (tx_clk),
		.reset_tx (reset_tx),
		.i_serial (i_serial),
		.smp      (smp_if)
	);

	uart_rx_fsm #(
		.DATA_WIDTH  (DATA_WIDTH),
		.PARITY_MODE (PARITY_MODE)
	) uart_rx_fsm_i (
		.tx_clk       (tx_clk),
		.reset_tx     (reset_tx),
		.smp          (smp_if),
		.o_rx_data    (o_rx_data),
		.o_data_valid (o_data_valid),
		.o_rx_error   (o_rx_error)
	);

endmodule

`default_nettype wire

//--- dv/uart_checker.sv
`timescale 1ns/10ps
`default_nettype none

module uart_checker #(
	parameter int                     DATA_WIDTH     = 8,
	parameter int                     CLOCKS_PER_BIT = 8,
	parameter uart_pkg::parity_mode_e PARITY_MODE    = uart_pkg::PARITY_EVEN
) (
	input  logic                  tx_clk,
	input  logic                  reset_tx,
	input  logic                  i_enable,
	input  logic [DATA_WIDTH-1:0] i_data,
	input  logic                  i_busy,
	input  logic                  i_serial_tx,   // o_serial of the dut
	input  logic [DATA_WIDTH-1:0] i_rx_data,
	input  logic                  i_data_valid,
	input  logic                  i_rx_error,
	input  logic [DATA_WIDTH-1:0] i_exp_data,    // copy of the current table row
	input  logic                  i_exp_err,
	input  logic                  i_exp_valid,   // row should end in one valid pulse
	input  logic                  i_exp_tx,      // row should put one word on o_serial
	input  logic                  i_row_done,    // one cycle at the end of each row
	output int                    o_value_errors,
	output int                    o_event_errors
);

	import uart_pkg::*;

	localparam int FRAME_BITS   = 2 + DATA_WIDTH + ((PARITY_MODE == PARITY_NONE) ? 0 : 1);
	localparam int FRAME_CYCLES = FRAME_BITS * CLOCKS_PER_BIT;

	logic [DATA_WIDTH-1:0] tx_word;      // word taken at acceptance
	logic                  tx_on = 1'b0;
	int                    tx_cycle;     // cycles since the accepting edge
	int                    valid_cnt = 0;
	int                    accept_cnt = 0;
	logic                  reset_seen = 1'b0;
	logic                  enable_seen = 1'b0;

	initial begin
		o_value_errors = 0;
		o_event_errors = 0;
	end

	// line level expected during frame bit idx
	function automatic logic frame_bit(input logic [DATA_WIDTH-1:0] w, input int idx);
		int ones;
		ones = 0;
		for (int i = 0; i < DATA_WIDTH; i++) begin
			ones += int'(w[i]);
		end
		if (idx == 0) begin
			frame_bit = 1'b0;  // start
		end else if (idx <= DATA_WIDTH) begin
			frame_bit = w[idx-1];  // lsb first
		end else if (idx == FRAME_BITS - 1) begin
			frame_bit = 1'b1;  // stop
		end else begin
			frame_bit = (ones % 2 == 1) ^ (PARITY_MODE == PARITY_ODD);
		end
	endfunction

	task automatic report_mismatch(input string msg);
		$display("ERROR %0t: %s", $time, msg);
		o_value_errors++;
	endtask

	task automatic report_event(input string msg);
		$display("at time %0t: %s", $time, msg);
		o_event_errors++;
	endtask

	always @(posedge tx_clk) begin
		if (reset_tx) begin
			reset_seen = 1'b1;
			tx_on      = 1'b0;
		end else begin
			if (reset_seen && !enable_seen && (i_serial_tx !== 1'b1 || i_busy !== 1'b0
					|| i_data_valid !== 1'b0 || i_rx_error !== 1'b0 || i_rx_data !== '0)) begin
				report_mismatch("outputs differ from their reset values");
			end
			if (i_enable) enable_seen = 1'b1;
			if (i_data_valid === 1'b1) begin
				valid_cnt++;
				if (!i_exp_valid || valid_cnt > 1) begin
					report_event("valid pulse where no received word was due");
				end else if (i_rx_data !== i_exp_data || i_rx_error !== i_exp_err) begin
					report_mismatch($sformatf("rx data %h err %b, expected %h err %b",
						i_rx_data, i_rx_error, i_exp_data, i_exp_err));
				end
			end else if (i_rx_error !== 1'b0) begin
				report_mismatch("rx error high without valid");
			end
			if (tx_on) begin
				tx_cycle++;
				if (tx_cycle <= FRAME_CYCLES && i_busy !== 1'b1) begin
					report_mismatch($sformatf("busy low at frame cycle %0d", tx_cycle));
				end
				if (tx_cycle <= FRAME_CYCLES
						&& tx_cycle % CLOCKS_PER_BIT == CLOCKS_PER_BIT / 2 + 1
						&& i_serial_tx !== frame_bit(tx_word, (tx_cycle - 1) / CLOCKS_PER_BIT)) begin
					report_mismatch($sformatf("tx bit %0d is %b, expected %b",
						(tx_cycle - 1) / CLOCKS_PER_BIT, i_serial_tx,
						frame_bit(tx_word, (tx_cycle - 1) / CLOCKS_PER_BIT)));
				end
				if (tx_cycle == FRAME_CYCLES + 1) begin
					tx_on = 1'b0;
					if (i_busy !== 1'b0) report_mismatch("busy still high after the stop bit");
					if (i_exp_valid && valid_cnt == 0) begin
						report_event("no valid pulse before the transmitter went idle");
					end
				end
			end
			if (i_enable && i_busy === 1'b0) begin  // dut takes the word on this edge
				tx_on    = 1'b1;
				tx_cycle = 0;
				tx_word  = i_data;
				accept_cnt++;
			end
			if (i_row_done) begin
				if (i_exp_valid && !i_exp_tx && valid_cnt == 0) begin
					report_event("no valid pulse for the injected frame");
				end
				if (accept_cnt != int'(i_exp_tx)) begin
					report_event($sformatf("transmitter took %0d words in this row, expected %0d",
						accept_cnt, i_exp_tx));
				end
				valid_cnt  = 0;
				accept_cnt = 0;
			end
		end
	end

endmodule

`default_nettype wire

//--- dv/uart_tb.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tb;

	localparam int DATA_WIDTH     = 8;
	localparam int CLOCKS_PER_BIT = 8;
	localparam int HALF_PERIOD_NS = 20;
	localparam int FRAME_BITS     = 2 + DATA_WIDTH + 1;  // even parity in the default dut
	localparam int NUM_ROWS       = 12;
	localparam int GLITCH_CYCLES  = CLOCKS_PER_BIT / 2 - 2;  // below half a bit minus one
	localparam int WATCHDOG_NS    = NUM_ROWS * (FRAME_BITS + 4) * CLOCKS_PER_BIT * 40 * 2;

	localparam logic [2:0] MODE_LOOP     = 3'd0;  // word through tx, i_serial follows o_serial
	localparam logic [2:0] MODE_BUSY     = 3'd1;  // second enable while the first word is out
	localparam logic [2:0] MODE_BAD_PAR  = 3'd2;
	localparam logic [2:0] MODE_BAD_STOP = 3'd3;
	localparam logic [2:0] MODE_GLITCH   = 3'd4;  // short low pulse on an idle line

	logic                  tx_clk = 1'b0;
	logic                  reset_tx, i_enable, o_busy, o_serial, i_serial;
	logic [DATA_WIDTH-1:0] i_data, o_rx_data;
	logic                  o_data_valid, o_rx_error;
	logic                  loop_on, inject_q;  // line source select and bit-banged level
	logic [DATA_WIDTH-1:0] exp_data;
	logic                  exp_err, exp_valid, exp_tx, row_done;
	int                    value_errors, event_errors, wait_errors;
	logic [31:0]           lfsr;

	logic [2:0]            tbl_mode     [NUM_ROWS];
	logic                  tbl_rand     [NUM_ROWS];  // word drawn from the lfsr
	logic [DATA_WIDTH-1:0] tbl_data     [NUM_ROWS];
	logic [DATA_WIDTH-1:0] tbl_exp_data [NUM_ROWS];  // drawn words expect themselves
	logic                  tbl_exp_err  [NUM_ROWS];

	always #(HALF_PERIOD_NS) tx_clk = ~tx_clk;

	assign i_serial = loop_on ? o_serial : inject_q;

	uart_top uart_top_i (
		.tx_clk(tx_clk), .reset_tx(reset_tx), .i_enable(i_enable), .i_data(i_data),
		.o_busy(o_busy), .o_serial(o_serial), .i_serial(i_serial), .o_rx_data(o_rx_data),
		.o_data_valid(o_data_valid), .o_rx_error(o_rx_error)
	);

	uart_checker #(.DATA_WIDTH(DATA_WIDTH), .CLOCKS_PER_BIT(CLOCKS_PER_BIT)) checker_i (
		.tx_clk(tx_clk), .reset_tx(reset_tx), .i_enable(i_enable), .i_data(i_data),
		.i_busy(o_busy), .i_serial_tx(o_serial), .i_rx_data(o_rx_data),
		.i_data_valid(o_data_valid), .i_rx_error(o_rx_error), .i_exp_data(exp_data),
		.i_exp_err(exp_err), .i_exp_valid(exp_valid), .i_exp_tx(exp_tx),
		.i_row_done(row_done), .o_value_errors(value_errors), .o_event_errors(event_errors)
	);

	task automatic set_row(input int r, input logic [2:0] mode, input logic rnd,
			input logic [DATA_WIDTH-1:0] data, input logic [DATA_WIDTH-1:0] want, input logic err);
		tbl_mode[r]     = mode;
		tbl_rand[r]     = rnd;
		tbl_data[r]     = data;
		tbl_exp_data[r] = want;
		tbl_exp_err[r]  = err;
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {1'b0, s[31:1]} ^ (s[0] ? 32'hA300_0000 : 32'h0);  // galois, shift right
	endfunction

	task automatic draw_word(output logic [DATA_WIDTH-1:0] w);
		for (int i = 0; i < DATA_WIDTH; i++) begin
			lfsr = lfsr_next(lfsr);  // one step per bit
			w[i] = lfsr[0];
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge tx_clk);
	endtask

	task automatic drive_bit(input logic b);
		inject_q = b;
		idle_cycles(CLOCKS_PER_BIT);
	endtask

	task automatic inject_frame(input logic [DATA_WIDTH-1:0] w, input logic flip_par,
			input logic stop);
		drive_bit(1'b0);
		for (int i = 0; i < DATA_WIDTH; i++) begin
			drive_bit(w[i]);
		end
		drive_bit((^w) ^ flip_par);  // even parity, optionally wrong
		drive_bit(stop);
		inject_q = 1'b1;
	endtask

	task automatic send_word(input logic [DATA_WIDTH-1:0] w);
		i_data   = w;
		i_enable = 1'b1;
		idle_cycles(1);
		i_enable = 1'b0;
	endtask

	task automatic wait_tx_idle;
		int n;
		n = 0;
		while (o_busy && n < 2 * FRAME_BITS * CLOCKS_PER_BIT) begin
			idle_cycles(1);
			n++;
		end
		if (o_busy) begin
			$display("transmitter still busy long after its frame should have ended");
			wait_errors++;
		end
	endtask

	initial begin
		logic [DATA_WIDTH-1:0] word;
		reset_tx = 1'b1;
		i_enable = 1'b0;
		i_data   = '0;
		loop_on  = 1'b0;
		inject_q = 1'b1;  // idle line
		exp_data = '0;
		exp_err  = 1'b0;
		exp_valid = 1'b0;
		exp_tx   = 1'b0;
		row_done = 1'b0;
		wait_errors = 0;
		lfsr = 32'h570;
		set_row(0, MODE_LOOP, 1'b0, 8'h55, 8'h55, 1'b0);
		set_row(1, MODE_LOOP, 1'b0, 8'hA3, 8'hA3, 1'b0);
		set_row(2, MODE_LOOP, 1'b0, 8'h00, 8'h00, 1'b0);
		set_row(3, MODE_LOOP, 1'b0, 8'hFF, 8'hFF, 1'b0);
		set_row(4, MODE_LOOP, 1'b1, 8'h00, 8'h00, 1'b0);
		set_row(5, MODE_LOOP, 1'b1, 8'h00, 8'h00, 1'b0);
		set_row(6, MODE_LOOP, 1'b1, 8'h00, 8'h00, 1'b0);
		set_row(7, MODE_BUSY, 1'b0, 8'h3C, 8'h3C, 1'b0);
		set_row(8, MODE_BAD_PAR, 1'b0, 8'h96, 8'h96, 1'b1);
		set_row(9, MODE_BAD_STOP, 1'b0, 8'h4E, 8'h4E, 1'b1);
		set_row(10, MODE_GLITCH, 1'b0, 8'h00, 8'h00, 1'b0);
		set_row(11, MODE_LOOP, 1'b0, 8'h81, 8'h81, 1'b0);
		idle_cycles(2);  // two rising edges in reset
		reset_tx = 1'b0;
		idle_cycles(4);
		for (int r = 0; r < NUM_ROWS; r++) begin
			word = tbl_data[r];
			if (tbl_rand[r]) draw_word(word);
			exp_data  = tbl_rand[r] ? word : tbl_exp_data[r];
			exp_err   = tbl_exp_err[r];
			exp_valid = (tbl_mode[r] != MODE_GLITCH);
			exp_tx    = (tbl_mode[r] == MODE_LOOP) || (tbl_mode[r] == MODE_BUSY);
			loop_on   = exp_tx;
			case (tbl_mode[r])
				MODE_LOOP: begin
					send_word(word);
					wait_tx_idle();
				end
				MODE_BUSY: begin
					send_word(word);
					idle_cycles(3 * CLOCKS_PER_BIT);
					send_word(~word);  // must be ignored
					wait_tx_idle();
				end
				MODE_BAD_PAR:  inject_frame(word, 1'b1, 1'b1);
				MODE_BAD_STOP: inject_frame(word, 1'b0, 1'b0);
				default: begin
					inject_q = 1'b0;
					idle_cycles(GLITCH_CYCLES);
					inject_q = 1'b1;
				end
			endcase
			idle_cycles(2 * CLOCKS_PER_BIT);  // receiver back to idle
			row_done = 1'b1;
			idle_cycles(1);
			row_done = 1'b0;
		end
		idle_cycles(4);
		$display("errors: value %0d, event %0d, wait %0d", value_errors, event_errors,
			wait_errors);
		if (value_errors + event_errors + wait_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the test sequence did not finish", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
design/uart_pkg.sv
design/rx_sample_if.sv
design/uart_tx.sv
design/uart_rx_front.sv
design/uart_rx_fsm.sv
design/uart_top.sv
dv/uart_checker.sv
dv/uart_tb.sv

//--- Bender.yml
package:
  name: uart_pair

sources:
  - design/uart_pkg.sv
  - design/rx_sample_if.sv
  - design/uart_tx.sv
  - design/uart_rx_front.sv
  - design/uart_rx_fsm.sv
  - design/uart_top.sv
  - target: test
    files:
      - dv/uart_checker.sv
      - dv/uart_tb.sv
